// ==== verilog/digitizer_defines.svh ====
`ifndef DIGITIZER_DEFINES_SVH
`define DIGITIZER_DEFINES_SVH

// --------------------
// Serial line timing
// --------------------
// System clocks per UART bit, both directions
`define CLKS_PER_BIT 16

// --------------------
// Capture storage
// --------------------
// Sample FIFO holds 2**N words
`define FIFO_DEPTH_LOG2 4
// Words per burst until the host sends a length
`define DEFAULT_BURST 4

`endif

// ==== verilog/digitizerPkg.sv ====
package digitizerPkg;

    // One registered ADC word
    typedef logic [31:0] sample_t;

    // --------------------
    // Host command bytes
    // --------------------
    localparam logic [7:0] CMD_ARM      = 8'h41;  // 'A'
    localparam logic [7:0] CMD_FORCE    = 8'h46;  // 'F'
    localparam logic [7:0] CMD_ECHO_ON  = 8'h45;  // 'E'
    localparam logic [7:0] CMD_ECHO_OFF = 8'h65;  // 'e'
    // 'L', the byte after it is the burst length
    localparam logic [7:0] CMD_LENGTH   = 8'h4c;

    // --------------------
    // FSM encodings
    // --------------------
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_ARMED,
        CAP_CAPTURING
    } captureState_t;

    typedef enum logic {
        DEC_COMMAND,
        DEC_LENGTH_ARG
    } decodeState_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} txState_t;

endpackage

// ==== verilog/captureCtrlIf.sv ====
`timescale 1ns/10ps

interface captureCtrlIf;
    // Request a new capture, one-cycle pulse
    logic       arm;
    // Trigger now, without waiting for an edge
    logic       forceTrigger;
    // Words per burst, 0 stands for 256
    logic [7:0] burstLen;
    // Capture armed or running
    logic       active;

    modport decoder (
        output arm, forceTrigger, burstLen,
        input  active
    );
    modport capture (
        input  arm, forceTrigger, burstLen,
        output active
    );
endinterface

// ==== verilog/uartRx.sv ====
`timescale 1ns/10ps

`include "digitizer_defines.svh"

module uartRx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rxByte,
    output logic       rxStrobe
);

    localparam int cntWidth = $clog2(`CLKS_PER_BIT);
    localparam int halfBit  = `CLKS_PER_BIT / 2;

    // Two-flop synchronizer on the serial input
    logic                rxMeta;
    logic                rxSync;

    // Frame in progress
    logic                busy;
    // Clocks left to the next bit centre
    logic [cntWidth-1:0] clkCount;
    // 0 start bit, 1..8 data, 9 stop
    logic [3:0]          bitIndex;
    logic [7:0]          shiftReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rxd;
            rxSync <= rxMeta;
        end
    end

    // --------------------
    // Frame sampler
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            clkCount <= '0;
            bitIndex <= '0;
            rxStrobe <= 1'b0;
        end else begin
            rxStrobe <= 1'b0;
            if (!busy) begin
                bitIndex <= '0;
                // Line dropped, aim for the middle of the start bit
                if (!rxSync) begin
                    busy     <= 1'b1;
                    clkCount <= cntWidth'(halfBit - 1);
                end
            end else if (clkCount != '0) begin
                clkCount <= clkCount - 1'b1;
            end else begin
                // At a bit centre
                clkCount <= cntWidth'(`CLKS_PER_BIT - 1);
                bitIndex <= bitIndex + 4'd1;
                if (bitIndex == 4'd0) begin
                    // Start bit gone high again, only a glitch
                    if (rxSync) begin
                        busy <= 1'b0;
                    end
                end else if (bitIndex == 4'd9) begin
                    busy     <= 1'b0;
                    rxByte   <= shiftReg;
                    // Low stop bit is a framing error, byte dropped
                    rxStrobe <= rxSync;
                end else begin
                    // LSB first, shift in from the top
                    shiftReg <= {rxSync, shiftReg[7:1]};
                end
            end
        end
    end

endmodule

// ==== verilog/cmdDecoder.sv ====
`timescale 1ns/10ps

`include "digitizer_defines.svh"

module cmdDecoder (
    input  logic          clk,
    input  logic          rst,
    input  logic [7:0]    rxByte,
    input  logic          rxStrobe,
    output logic [7:0]    echoByte,
    output logic          echoStrobe,
    output logic          echoOn,
    captureCtrlIf.decoder ctrl
);

    import digitizerPkg::*;

    decodeState_t state;

    // --------------------
    // Command interpreter
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= DEC_COMMAND;
            echoOn            <= 1'b0;
            echoStrobe        <= 1'b0;
            ctrl.arm          <= 1'b0;
            ctrl.forceTrigger <= 1'b0;
            ctrl.burstLen     <= 8'(`DEFAULT_BURST);
        end else begin
            // Control pulses last a single cycle
            ctrl.arm          <= 1'b0;
            ctrl.forceTrigger <= 1'b0;

            // Echo follows the mode from before this byte
            echoStrobe <= rxStrobe && echoOn;

            if (rxStrobe) begin
                echoByte <= rxByte;
                case (state)
                    DEC_COMMAND: begin
                        case (rxByte)
                            // No new arm while a capture is pending
                            CMD_ARM:      ctrl.arm <= !ctrl.active;
                            CMD_FORCE:    ctrl.forceTrigger <= 1'b1;
                            CMD_ECHO_ON:  echoOn <= 1'b1;
                            CMD_ECHO_OFF: echoOn <= 1'b0;
                            // Length value comes in the next byte
                            CMD_LENGTH:   state <= DEC_LENGTH_ARG;
                            // Unknown codes fall through
                            default: ;
                        endcase
                    end
                    DEC_LENGTH_ARG: begin
                        // Raw byte, 0 means a full 256-word burst
                        ctrl.burstLen <= rxByte;
                        state         <= DEC_COMMAND;
                    end
                    default: begin
                        state <= DEC_COMMAND;
                    end
                endcase
            end
        end
    end

endmodule

// ==== verilog/captureControl.sv ====
`timescale 1ns/10ps

module captureControl (
    input  logic                  clk,
    input  logic                  rst,
    input  digitizerPkg::sample_t adcData,
    input  logic                  adcStrobe,
    input  logic                  dataTrigger,
    input  logic                  full,
    output digitizerPkg::sample_t wrData,
    output logic                  wrEn,
    output logic                  capturing,
    output logic                  armed,
    output logic                  overflow,
    captureCtrlIf.capture         ctrl
);

    import digitizerPkg::*;

    captureState_t state;

    // Trigger input, registered then edge detected
    logic          trigSync;
    logic          trigPrev;
    logic          trigEdge;

    // Strobes still to take in this burst, up to 256
    logic [8:0]    remaining;

    assign trigEdge     = trigSync && !trigPrev;
    assign armed        = (state == CAP_ARMED);
    assign capturing    = (state == CAP_CAPTURING);
    assign ctrl.active  = (state != CAP_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            trigSync <= 1'b0;
            trigPrev <= 1'b0;
        end else begin
            trigSync <= dataTrigger;
            trigPrev <= trigSync;
        end
    end

    // --------------------
    // Arm / trigger FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= CAP_IDLE;
            remaining <= '0;
            wrEn      <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            case (state)
                CAP_IDLE: begin
                    if (ctrl.arm) begin
                        state    <= CAP_ARMED;
                        overflow <= 1'b0;
                    end
                end
                CAP_ARMED: begin
                    if (trigEdge || ctrl.forceTrigger) begin
                        state     <= CAP_CAPTURING;
                        remaining <= (ctrl.burstLen == 8'd0) ? 9'd256 : {1'b0, ctrl.burstLen};
                    end
                end
                CAP_CAPTURING: begin
                    if (adcStrobe) begin
                        // Word lands in the FIFO one cycle later
                        wrEn      <= 1'b1;
                        wrData    <= adcData;
                        remaining <= remaining - 9'd1;
                        if (remaining == 9'd1) begin
                            state <= CAP_IDLE;
                        end
                    end
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
            // FIFO refused the registered word, sticky until next arm
            if (wrEn && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/sampleFifo.sv ====
`timescale 1ns/10ps

`include "digitizer_defines.svh"

module sampleFifo #(
    parameter int depthLog2 = `FIFO_DEPTH_LOG2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  digitizerPkg::sample_t wrData,
    input  logic                  wrEn,
    input  logic                  rdEn,
    output digitizerPkg::sample_t rdData,
    output logic                  empty,
    output logic                  full
);

    import digitizerPkg::*;

    localparam int depth = 1 << depthLog2;

    sample_t            mem [depth];

    // Extra top bit tells a full ring from an empty one
    logic [depthLog2:0] wrPtr;
    logic [depthLog2:0] rdPtr;

    logic               doWrite;
    logic               doRead;

    assign empty   = (wrPtr == rdPtr);
    assign full    = (wrPtr[depthLog2] != rdPtr[depthLog2]) &&
                     (wrPtr[depthLog2-1:0] == rdPtr[depthLog2-1:0]);
    // Out-of-range requests are dropped here
    assign doWrite = wrEn && !full;
    assign doRead  = rdEn && !empty;

    // Head word shows without a read
    assign rdData  = mem[rdPtr[depthLog2-1:0]];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr[depthLog2-1:0]] <= wrData;
        end
    end

    // --------------------
    // Pointers
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doWrite) wrPtr <= wrPtr + 1'b1;
            if (doRead)  rdPtr <= rdPtr + 1'b1;
        end
    end

endmodule

// ==== verilog/uartTransmitter.sv ====
`timescale 1ns/10ps

`include "digitizer_defines.svh"

module uartTransmitter #(
    parameter int clksPerBit = `CLKS_PER_BIT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            echoByte,
    input  logic                  echoStrobe,
    input  digitizerPkg::sample_t rdData,
    input  logic                  empty,
    output logic                  rdEn,
    output logic                  txd
);

    import digitizerPkg::*;

    localparam int                  cntWidth  = $clog2(clksPerBit);
    localparam logic [cntWidth-1:0] lastCount = cntWidth'(clksPerBit - 1);

    txState_t            state;
    logic [cntWidth-1:0] clkCount;
    logic [2:0]          bitIndex;
    logic [7:0]          shiftReg;

    // Single echo slot
    logic                echoPending;
    logic [7:0]          echoHold;

    // Unsent part of the current word, next byte on top
    sample_t             wordBuf;
    logic [1:0]          bytesLeft;

    // Something ready for the next frame
    logic                haveByte;

    assign haveByte = echoPending || (bytesLeft != 2'd0) || !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= TX_IDLE;
            clkCount    <= '0;
            bitIndex    <= '0;
            txd         <= 1'b1;
            rdEn        <= 1'b0;
            echoPending <= 1'b0;
            bytesLeft   <= '0;
        end else begin
            rdEn <= 1'b0;
            // Echo only into an empty slot, later ones are lost
            if (echoStrobe && !echoPending) begin
                echoPending <= 1'b1;
                echoHold    <= echoByte;
            end

            case (state)
                // --------------------
                // Pick the next byte
                // --------------------
                TX_IDLE: begin
                    clkCount <= '0;
                    if (haveByte) begin
                        txd   <= 1'b0;
                        state <= TX_START;
                    end
                    if (echoPending) begin
                        echoPending <= 1'b0;
                        shiftReg    <= echoHold;
                    end else if (bytesLeft != 2'd0) begin
                        bytesLeft <= bytesLeft - 2'd1;
                        shiftReg  <= wordBuf[31:24];
                        wordBuf   <= wordBuf << 8;
                    end else if (!empty) begin
                        // Pop the head word, MSB goes out first
                        rdEn      <= 1'b1;
                        bytesLeft <= 2'd3;
                        shiftReg  <= rdData[31:24];
                        wordBuf   <= rdData << 8;
                    end
                end
                TX_START: begin
                    clkCount <= clkCount + 1'b1;
                    if (clkCount == lastCount) begin
                        clkCount <= '0;
                        bitIndex <= '0;
                        txd      <= shiftReg[0];
                        shiftReg <= shiftReg >> 1;
                        state    <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    clkCount <= clkCount + 1'b1;
                    if (clkCount == lastCount) begin
                        clkCount <= '0;
                        if (bitIndex == 3'd7) begin
                            txd   <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            bitIndex <= bitIndex + 3'd1;
                            txd      <= shiftReg[0];
                            shiftReg <= shiftReg >> 1;
                        end
                    end
                end
                TX_STOP: begin
                    clkCount <= clkCount + 1'b1;
                    if (clkCount == lastCount) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/digitizerTop.sv ====
`timescale 1ns/10ps

`include "digitizer_defines.svh"

module digitizerTop (
    input  logic        clk,
    input  logic        rst,
    input  logic        rxd,
    output logic        txd,
    input  logic [31:0] adcData,
    input  logic        adcStrobe,
    input  logic        dataTrigger,
    output logic [3:0]  led
);

    import digitizerPkg::*;

    // Host receive path
    logic [7:0] rxByte;
    logic       rxStrobe;
    logic [7:0] echoByte;
    logic       echoStrobe;
    logic       echoOn;

    // Sample path
    sample_t    wrData;
    sample_t    rdData;
    logic       wrEn;
    logic       rdEn;
    logic       empty;
    logic       full;

    // Capture status
    logic       armed;
    logic       capturing;
    logic       overflow;

    captureCtrlIf ctrlBus ();

    // --------------------
    // Command side
    // --------------------
    uartRx rx (.clk, .rst, .rxd, .rxByte, .rxStrobe);

    cmdDecoder decoder (
        .clk, .rst, .rxByte, .rxStrobe, .echoByte, .echoStrobe, .echoOn,
        .ctrl (ctrlBus.decoder)
    );

    // --------------------
    // Data side
    // --------------------
    captureControl capture (
        .clk, .rst, .adcData, .adcStrobe, .dataTrigger, .full,
        .wrData, .wrEn, .capturing, .armed, .overflow,
        .ctrl (ctrlBus.capture)
    );

    sampleFifo #(.depthLog2(`FIFO_DEPTH_LOG2)) fifo (
        .clk, .rst, .wrData, .wrEn, .rdEn, .rdData, .empty, .full
    );

    uartTransmitter #(.clksPerBit(`CLKS_PER_BIT)) tx (
        .clk, .rst, .echoByte, .echoStrobe, .rdData, .empty, .rdEn, .txd
    );

    // Armed, capturing, echo, overflow from bit 0 up
    assign led = {overflow, echoOn, capturing, armed};

endmodule

// ==== test/digitizerTb.sv ====
`timescale 1ns/10ps

`include "digitizer_defines.svh"

module digitizerTb;

    localparam int bitClocks    = `CLKS_PER_BIT;
    // Idle txd cycles that count as a quiet transmitter
    localparam int quietLimit   = 4 * `CLKS_PER_BIT;
    localparam int byteTimeout  = 5000;
    localparam int quietTimeout = 200000;

    logic        clk;
    logic        rst;
    logic        rxd;
    logic        txd;
    logic [31:0] adcData;
    logic        adcStrobe;
    logic        dataTrigger;
    logic [3:0]  led;

    // Bytes seen on txd in arrival order
    logic [7:0]  rxQueue [$];

    // txd monitor state
    logic        monBusy;
    int          monCount;
    int          monBit;
    logic [7:0]  monShift;
    int          quietCount;

    int          stimFile;

    digitizerTop dut (
        .clk, .rst, .rxd, .txd, .adcData, .adcStrobe, .dataTrigger, .led
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // --------------------
    // txd frame monitor
    // --------------------
    // Samples on the falling edge away from DUT updates
    always @(negedge clk) begin
        if (rst) begin
            monBusy    = 1'b0;
            quietCount = 0;
        end else if (!monBusy) begin
            if (!txd) begin
                // First sample after the start edge lands near mid-bit
                monBusy    = 1'b1;
                monCount   = bitClocks / 2;
                monBit     = 0;
                quietCount = 0;
            end else if (quietCount < quietTimeout) begin
                quietCount++;
            end
        end else begin
            monCount--;
            if (monCount == 0) begin
                monCount = bitClocks;
                if (monBit == 0) begin
                    assert (!txd) else abortRun("Start bit on txd did not stay low");
                end else if (monBit == 9) begin
                    assert (txd) else abortRun("Stop bit on txd was low");
                    rxQueue.push_back(monShift);
                    monBusy = 1'b0;
                end else begin
                    // LSB arrives first
                    monShift = {txd, monShift[7:1]};
                end
                monBit++;
            end
        end
    end

    // --------------------
    // Host and ADC drivers
    // --------------------
    task sendHostByte(input logic [7:0] b);
        int i;
        @(negedge clk);
        rxd = 1'b0;
        repeat (bitClocks) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rxd = b[i];
            repeat (bitClocks) @(negedge clk);
        end
        // Stop bit plus a short idle gap
        rxd = 1'b1;
        repeat (bitClocks + 2) @(negedge clk);
    endtask

    task pulseTrigger;
        @(negedge clk);
        dataTrigger = 1'b1;
        repeat (4) @(negedge clk);
        dataTrigger = 1'b0;
        @(negedge clk);
    endtask

    task streamSamples(input int count, input logic [31:0] start, input int maxGap);
        int i;
        int gap;
        @(negedge clk);
        for (i = 0; i < count; i++) begin
            adcData   = start + 32'(i);
            adcStrobe = 1'b1;
            @(negedge clk);
            adcStrobe = 1'b0;
            // Gap of 0 keeps the strobe high back to back
            gap = int'($urandom % 32'(maxGap + 1));
            repeat (gap) @(negedge clk);
        end
    endtask

    // --------------------
    // Response checks
    // --------------------
    task popByte(output logic [7:0] b);
        int cycles;
        cycles = 0;
        while (rxQueue.size() == 0 && cycles < byteTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (rxQueue.size() == 0) begin
            abortRun("Timed out waiting for a byte on txd");
        end
        b = rxQueue.pop_front();
    endtask

    task expectByte(input logic [7:0] exp);
        logic [7:0] got;
        popByte(got);
        assert (got == exp) else
            abortRun($sformatf("FAIL %0t: byte expected %h, got %h", $time, exp, got));
    endtask

    task readWord(output logic [31:0] word);
        logic [7:0] b;
        int         i;
        word = '0;
        // Most significant byte comes first
        for (i = 0; i < 4; i++) begin
            popByte(b);
            word = {word[23:0], b};
        end
    endtask

    task expectWord(input logic [31:0] exp);
        logic [31:0] got;
        readWord(got);
        assert (got == exp) else
            abortRun($sformatf("FAIL %0t: word expected %h, got %h", $time, exp, got));
    endtask

    task expectLeds(input logic [3:0] mask);
        @(negedge clk);
        assert (led == mask) else
            abortRun($sformatf("FAIL %0t: led expected %b, got %b", $time, mask, led));
    endtask

    task waitQuiet;
        int cycles;
        cycles = 0;
        while (quietCount < quietLimit && cycles < quietTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (quietCount < quietLimit) begin
            abortRun("Timed out waiting for the transmitter to go quiet");
        end
    endtask

    task expectSilence;
        assert (rxQueue.size() == 0) else
            abortRun($sformatf("FAIL %0t: %0d unexpected bytes on txd", $time, rxQueue.size()));
    endtask

    // Survivors of an overflowed burst must be in range and rising
    task checkCollectedWords(input int count, input logic [31:0] start);
        int          words;
        int          i;
        logic [31:0] word;
        logic [31:0] prev;
        waitQuiet();
        words = rxQueue.size() / 4;
        assert (rxQueue.size() % 4 == 0 && words > 0 && words <= count) else
            abortRun($sformatf("FAIL %0t: %0d bytes are not 1 to %0d whole words",
                               $time, rxQueue.size(), count));
        prev = '0;
        for (i = 0; i < words; i++) begin
            readWord(word);
            assert (word >= start && word < start + 32'(count) && (i == 0 || word > prev)) else
                abortRun($sformatf("FAIL %0t: word %h out of range or order", $time, word));
            prev = word;
        end
    endtask

    // --------------------
    // Stimulus file
    // --------------------
    task runOp(input string op);
        logic [31:0] argA;
        logic [31:0] argB;
        logic [31:0] argC;
        int          code;
        string       rest;
        case (op)
            "#": code = $fgets(rest, stimFile);
            "S": begin
                code = $fscanf(stimFile, "%h", argA);
                sendHostByte(argA[7:0]);
            end
            "T": pulseTrigger();
            "D": begin
                code = $fscanf(stimFile, "%h %h %h", argA, argB, argC);
                streamSamples(int'(argA), argB, int'(argC));
            end
            "B": begin
                code = $fscanf(stimFile, "%h", argA);
                expectByte(argA[7:0]);
            end
            "W": begin
                code = $fscanf(stimFile, "%h", argA);
                expectWord(argA);
            end
            "M": begin
                code = $fscanf(stimFile, "%h", argA);
                expectLeds(argA[3:0]);
            end
            "Q": waitQuiet();
            "N": expectSilence();
            "C": begin
                code = $fscanf(stimFile, "%h %h", argA, argB);
                checkCollectedWords(int'(argA), argB);
            end
            default: abortRun({"Unknown operation in stimulus file: ", op});
        endcase
    endtask

    initial begin
        string op;
        int    code;
        logic  finished;
        rst         = 1'b1;
        rxd         = 1'b1;
        adcData     = '0;
        adcStrobe   = 1'b0;
        dataTrigger = 1'b0;
        finished    = 1'b0;
        void'($urandom(32'hdaf1_a9a5));
        stimFile    = $fopen("test/digitizerStim.txt", "r");
        if (stimFile == 0) begin
            abortRun("Could not open test/digitizerStim.txt");
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (!finished) begin
            code = $fscanf(stimFile, "%s", op);
            if (code != 1) begin
                finished = 1'b1;
            end else begin
                runOp(op);
            end
        end
        $fclose(stimFile);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== test/digitizerStim.txt ====
# Columns: op then hex args. S byte | T | D count start maxgap | B byte | W word
# M ledmask | Q quiet | N no byte | C count start (overflowed burst)
Q
N
M 0
S 45
M 4
S 78
B 78
S 65
B 65
M 0
S 79
Q
N
S 4c
S 03
S 41
M 1
S 46
M 2
D 3 11223344 3
M 0
W 11223344
W 11223345
W 11223346
Q
N
D 4 a0000000 2
T
Q
N
M 0
S 41
M 1
T
M 2
D 3 c0ffee00 3
M 0
D 2 d0000000 1
W c0ffee00
W c0ffee01
W c0ffee02
Q
N
S 4c
S 28
S 41
S 46
D 28 50000000 0
M 8
C 28 50000000
M 8
S 4c
S 02
S 41
M 1
S 46
D 2 60000000 3
M 0
W 60000000
W 60000001
Q
N

// ==== build.f ====
+incdir+verilog
verilog/digitizerPkg.sv
verilog/captureCtrlIf.sv
verilog/uartRx.sv
verilog/cmdDecoder.sv
verilog/captureControl.sv
verilog/sampleFifo.sv
verilog/uartTransmitter.sv
verilog/digitizerTop.sv
test/digitizerTb.sv

// ==== Makefile ====
# Verilator flow for the digitizer testbench

TOP := digitizerTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
		-f build.f --top-module $(TOP) -o $(TOP)

# Status comes from the grep for the pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
